//--- src/bd_pkg.sv
package bd_pkg;

  // raw chip word is {leaf code, payload}
  localparam int BD_RAW_W  = 40;
  localparam int LEAF_W    = 6;
  localparam int PAYLOAD_W = 34;

  // default field widths of a tag payload
  localparam int NGLOBAL = 8;
  localparam int NTAG    = 11;
  localparam int NCT     = 9;

  // leaf codes carrying tag words
  localparam logic [LEAF_W-1:0] RO_ACC_CODE = 6'd11;
  localparam logic [LEAF_W-1:0] RO_TAT_CODE = 6'd12;

  // global tag that routes a tag word back to the host (-32)
  localparam logic signed [NGLOBAL-1:0] GO_HOME_RT = 8'shE0;

  // payload width per leaf, zero marks a leaf the decoder does not know
  localparam int unsigned leaf_payload_w [64] = '{
    0: 21, 1: 34, 2: 16, 3: 20, 4: 12, 5: 8, 6: 32, 7: 19,
    11: 34, 12: 34, 13: 24, 14: 2,
    default: 0
  };

  // one payload word, read as plain data or as a tag word
  typedef union packed {
    logic [PAYLOAD_W-1:0] data;
    struct packed {
      logic [PAYLOAD_W-NGLOBAL-NTAG-NCT-1:0] pad;
      logic [NGLOBAL-1:0]                    global_tag;
      logic [NTAG-1:0]                       tag;
      logic [NCT-1:0]                        ct;
    } tg;
  } bd_payload_u;

  typedef enum logic [1:0] {
    KIND_OTHER = 2'd0,
    KIND_TAG   = 2'd1
  } host_kind_e;

  // host word is {kind, leaf code, payload}
  localparam int HOST_W = 2 + LEAF_W + PAYLOAD_W;

endpackage

//--- src/bd_word_decoder.sv
`timescale 1ns/1ps

module bd_word_decoder import bd_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                raw_v,
  output logic                raw_a,
  input  logic [BD_RAW_W-1:0] raw_word,
  output logic                dec_v,
  input  logic                dec_a,
  output logic [LEAF_W-1:0]   dec_leaf,
  output bd_payload_u         dec_payload,
  output logic [15:0]         drop_count
);

  logic [LEAF_W-1:0]    raw_leaf;
  bd_payload_u          raw_payload;
  bd_payload_u          masked_payload;
  logic [PAYLOAD_W-1:0] mask;
  int unsigned          leaf_w;
  logic                 leaf_known;
  logic                 take;
  logic                 load;

  assign raw_leaf    = raw_word[BD_RAW_W-1 -: LEAF_W];
  assign raw_payload = raw_word[PAYLOAD_W-1:0];

  assign leaf_w     = leaf_payload_w[raw_leaf];
  assign leaf_known = (leaf_w != 0);

  // keep only the low leaf_w bits, a zero width clears everything
  assign mask                = {PAYLOAD_W{1'b1}} >> (PAYLOAD_W - leaf_w);
  assign masked_payload.data = raw_payload.data & mask;

  // the register takes a new word in the cycle its held word leaves
  assign raw_a = ~dec_v | dec_a;
  assign take  = raw_v & raw_a;
  assign load  = take & leaf_known;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_v <= 1'b0;
    end else if (load) begin
      dec_v <= 1'b1;
    end else if (dec_a) begin
      dec_v <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      dec_leaf    <= raw_leaf;
      dec_payload <= masked_payload;
    end
  end

  // unknown leaves are swallowed here and only counted
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      drop_count <= '0;
    end else if (take && !leaf_known && drop_count != 16'hFFFF) begin
      drop_count <= drop_count + 16'd1;
    end
  end

  // a word offered downstream stays put until it is taken
  property p_dec_hold;
    @(posedge clk) disable iff (!arst_n)
      dec_v && !dec_a |=> dec_v && $stable(dec_leaf) && $stable(dec_payload);
  endproperty
  a_dec_hold: assert property (p_dec_hold)
    else $error("decoder output changed while stalled");

endmodule

//--- src/bd_tag_split.sv
`timescale 1ns/1ps

module bd_tag_split import bd_pkg::*; #(
  parameter int NGLOBAL = bd_pkg::NGLOBAL,
  parameter int NTAG    = bd_pkg::NTAG,
  parameter int NCT     = bd_pkg::NCT
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              dec_v,
  output logic              dec_a,
  input  logic [LEAF_W-1:0] dec_leaf,
  input  bd_payload_u       dec_payload,
  input  logic              report_tags,
  output logic              glb_v,
  input  logic              glb_a,
  output bd_payload_u       glb_payload,
  output logic              tag_v,
  input  logic              tag_a,
  output bd_payload_u       tag_payload,
  output logic              oth_v,
  input  logic              oth_a,
  output logic [LEAF_W-1:0] oth_leaf,
  output bd_payload_u       oth_payload
);

  logic [NGLOBAL-1:0] global_tag;
  logic               is_tag;
  logic               want_glb;
  logic               want_tag;
  logic               want_oth;
  logic               tag_taken_q;
  logic               oth_taken_q;
  logic               tag_done;
  logic               oth_done;

  // read the word as if it were a tag word, only used when it is one
  assign global_tag = dec_payload.data[NTAG + NCT +: NGLOBAL];

  assign is_tag   = (dec_leaf == RO_ACC_CODE) || (dec_leaf == RO_TAT_CODE);
  assign want_glb = is_tag && ($signed(global_tag) != GO_HOME_RT);
  assign want_tag = is_tag && !want_glb;
  assign want_oth = !is_tag || (want_tag && report_tags);

  // an output that already took this word stops offering it
  assign glb_v = dec_v & want_glb;
  assign tag_v = dec_v & want_tag & ~tag_taken_q;
  assign oth_v = dec_v & want_oth & ~oth_taken_q;

  assign glb_payload = dec_payload;
  assign tag_payload = dec_payload;
  assign oth_payload = dec_payload;
  assign oth_leaf    = dec_leaf;

  // an output is done when not chosen, already taken or taking now
  assign tag_done = ~want_tag | tag_taken_q | (tag_v & tag_a);
  assign oth_done = ~want_oth | oth_taken_q | (oth_v & oth_a);

  always_comb begin
    if (want_glb) begin
      dec_a = dec_v & glb_a;
    end else begin
      dec_a = dec_v & tag_done & oth_done;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tag_taken_q <= 1'b0;
      oth_taken_q <= 1'b0;
    end else if (dec_a) begin
      // word retires, next word starts with nothing taken
      tag_taken_q <= 1'b0;
      oth_taken_q <= 1'b0;
    end else begin
      if (tag_v && tag_a) begin
        tag_taken_q <= 1'b1;
      end
      if (oth_v && oth_a) begin
        oth_taken_q <= 1'b1;
      end
    end
  end

  // a valid word is owned either by the route table or by the host side
  property p_one_side;
    @(posedge clk) disable iff (!arst_n)
      dec_v |-> (glb_v ^ (tag_v | oth_v));
  endproperty
  a_one_side: assert property (p_one_side)
    else $error("word offered to both or neither side");

endmodule

//--- src/global_route_table.sv
`timescale 1ns/1ps

module global_route_table import bd_pkg::*; #(
  parameter int NGLOBAL = bd_pkg::NGLOBAL
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               cfg_we,
  input  logic [NGLOBAL-1:0] cfg_addr,
  input  logic [NGLOBAL-1:0] cfg_route,
  input  logic               glb_v,
  output logic               glb_a,
  input  bd_payload_u        glb_payload,
  output logic               chip_v,
  input  logic               chip_a,
  output bd_payload_u        chip_payload
);

  localparam int DEPTH = 2 ** NGLOBAL;

  logic [NGLOBAL-1:0] route_mem [DEPTH];
  bd_payload_u        routed;
  logic               load;

  // route memory, cleared on reset so unprogrammed tags map to zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        route_mem[i] <= '0;
      end
    end else if (cfg_we) begin
      route_mem[cfg_addr] <= cfg_route;
    end
  end

  // swap the global tag for its route, tag and count pass unchanged
  always_comb begin
    routed               = glb_payload;
    routed.tg.global_tag = route_mem[glb_payload.tg.global_tag];
  end

  assign glb_a = ~chip_v | chip_a;
  assign load  = glb_v & glb_a;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chip_v <= 1'b0;
    end else if (load) begin
      chip_v <= 1'b1;
    end else if (chip_a) begin
      chip_v <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      chip_payload <= routed;
    end
  end

endmodule

//--- src/host_uplink_arbiter.sv
`timescale 1ns/1ps

module host_uplink_arbiter import bd_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              tag_v,
  output logic              tag_a,
  input  bd_payload_u       tag_payload,
  input  logic              oth_v,
  output logic              oth_a,
  input  logic [LEAF_W-1:0] oth_leaf,
  input  bd_payload_u       oth_payload,
  output logic              host_v,
  input  logic              host_a,
  output logic [HOST_W-1:0] host_word
);

  logic              free;
  logic              grant_tag;
  logic              grant_oth;
  logic              oth_first_q;
  logic [HOST_W-1:0] next_word;

  // output register can take a word when empty or emptying now
  assign free = ~host_v | host_a;

  // oth_first_q picks the winner when both streams request
  assign grant_tag = free & tag_v & (~oth_v | ~oth_first_q);
  assign grant_oth = free & oth_v & (~tag_v | oth_first_q);

  assign tag_a = grant_tag;
  assign oth_a = grant_oth;

  always_comb begin
    if (grant_tag) begin
      next_word = {KIND_TAG, RO_TAT_CODE, tag_payload};
    end else begin
      next_word = {KIND_OTHER, oth_leaf, oth_payload};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      oth_first_q <= 1'b0;
    end else if (grant_tag || grant_oth) begin
      // the stream just served waits behind the other one
      oth_first_q <= grant_tag;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      host_v <= 1'b0;
    end else if (grant_tag || grant_oth) begin
      host_v <= 1'b1;
    end else if (host_a) begin
      host_v <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (grant_tag || grant_oth) begin
      host_word <= next_word;
    end
  end

  property p_one_grant;
    @(posedge clk) disable iff (!arst_n)
      !(tag_a && oth_a);
  endproperty
  a_one_grant: assert property (p_one_grant)
    else $error("both host streams granted together");

endmodule

//--- src/bd_uplink_top.sv
`timescale 1ns/1ps

module bd_uplink_top import bd_pkg::*; #(
  parameter int NGLOBAL = bd_pkg::NGLOBAL,
  parameter int NTAG    = bd_pkg::NTAG,
  parameter int NCT     = bd_pkg::NCT
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                raw_v,
  output logic                raw_a,
  input  logic [BD_RAW_W-1:0] raw_word,
  input  logic                report_tags,
  input  logic                cfg_we,
  input  logic [NGLOBAL-1:0]  cfg_addr,
  input  logic [NGLOBAL-1:0]  cfg_route,
  output logic                host_v,
  input  logic                host_a,
  output logic [HOST_W-1:0]   host_word,
  output logic                chip_v,
  input  logic                chip_a,
  output bd_payload_u         chip_payload,
  output logic [15:0]         drop_count
);

  // decoder to splitter
  logic              dec_v;
  logic              dec_a;
  logic [LEAF_W-1:0] dec_leaf;
  bd_payload_u       dec_payload;

  // splitter to route table
  logic              glb_v;
  logic              glb_a;
  bd_payload_u       glb_payload;

  // splitter to host arbiter
  logic              tag_v;
  logic              tag_a;
  bd_payload_u       tag_payload;
  logic              oth_v;
  logic              oth_a;
  logic [LEAF_W-1:0] oth_leaf;
  bd_payload_u       oth_payload;

  bd_word_decoder bd_word_decoder_i (
    .clk, .arst_n, .raw_v, .raw_a, .raw_word,
    .dec_v, .dec_a, .dec_leaf, .dec_payload, .drop_count
  );

  bd_tag_split #(.NGLOBAL(NGLOBAL), .NTAG(NTAG), .NCT(NCT)) bd_tag_split_i (
    .clk, .arst_n, .dec_v, .dec_a, .dec_leaf, .dec_payload, .report_tags,
    .glb_v, .glb_a, .glb_payload, .tag_v, .tag_a, .tag_payload,
    .oth_v, .oth_a, .oth_leaf, .oth_payload
  );

  global_route_table #(.NGLOBAL(NGLOBAL)) global_route_table_i (
    .clk, .arst_n, .cfg_we, .cfg_addr, .cfg_route,
    .glb_v, .glb_a, .glb_payload, .chip_v, .chip_a, .chip_payload
  );

  host_uplink_arbiter host_uplink_arbiter_i (
    .clk, .arst_n, .tag_v, .tag_a, .tag_payload,
    .oth_v, .oth_a, .oth_leaf, .oth_payload, .host_v, .host_a, .host_word
  );

endmodule

//--- verification/bd_uplink_checker.sv
`timescale 1ns/1ps

module bd_uplink_checker import bd_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 raw_v,
  input  logic                 raw_a,
  input  logic [BD_RAW_W-1:0]  raw_word,
  input  logic [2:0]           exp_dest,
  input  logic [PAYLOAD_W-1:0] exp_payload,
  input  logic                 cfg_we,
  input  logic [NGLOBAL-1:0]   cfg_addr,
  input  logic [NGLOBAL-1:0]   cfg_route,
  input  logic                 host_v,
  input  logic                 host_a,
  input  logic [HOST_W-1:0]    host_word,
  input  logic                 chip_v,
  input  logic                 chip_a,
  input  bd_payload_u          chip_payload,
  input  logic [15:0]          drop_count,
  output int                   err_count,
  output int                   chk_count,
  output logic                 drained
);

  localparam int PAD_W = HOST_W - PAYLOAD_W;

  // model of the route memory, built from the cfg writes seen on the port
  logic [NGLOBAL-1:0]   route_model [2**NGLOBAL];
  logic [HOST_W-1:0]    tag_q [$];
  logic [HOST_W-1:0]    oth_q [$];
  logic [PAYLOAD_W-1:0] chip_q [$];
  logic [15:0]          exp_drops;
  logic                 drop_due;

  task automatic compare_value(input string name, input logic [HOST_W-1:0] exp,
                               input logic [HOST_W-1:0] got);
    chk_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic report_extra(input string name, input logic [HOST_W-1:0] got);
    err_count++;
    $display("%s delivered %h at %0d ns while no word was pending", name, got, $time);
  endtask

  always @(posedge clk) begin
    bd_payload_u       routed;
    logic [LEAF_W-1:0] leaf;
    if (!arst_n) begin
      foreach (route_model[i]) begin
        route_model[i] = '0;
      end
      tag_q.delete();
      oth_q.delete();
      chip_q.delete();
      exp_drops = '0;
      drop_due  = 1'b0;
      err_count = 0;
      chk_count = 0;
      drained  <= 1'b1;
    end else begin
      // drop_count settles one edge after the word was taken
      if (drop_due) begin
        compare_value("drop_count", {{(HOST_W-16){1'b0}}, exp_drops},
                      {{(HOST_W-16){1'b0}}, drop_count});
        // follow the DUT so a single slip is reported once
        exp_drops = drop_count;
        drop_due  = 1'b0;
      end
      if (host_v && host_a) begin
        if (host_word[HOST_W-1 -: 2] == KIND_TAG) begin
          if (tag_q.size() == 0) begin
            report_extra("host_word", host_word);
          end else begin
            compare_value("host_word", tag_q.pop_front(), host_word);
          end
        end else if (oth_q.size() == 0) begin
          report_extra("host_word", host_word);
        end else begin
          compare_value("host_word", oth_q.pop_front(), host_word);
        end
      end
      if (chip_v && chip_a) begin
        if (chip_q.size() == 0) begin
          report_extra("chip_payload", {{PAD_W{1'b0}}, chip_payload.data});
        end else begin
          compare_value("chip_payload", {{PAD_W{1'b0}}, chip_q.pop_front()},
                        {{PAD_W{1'b0}}, chip_payload.data});
        end
      end
      if (raw_v && raw_a) begin
        leaf     = raw_word[BD_RAW_W-1 -: LEAF_W];
        drop_due = 1'b1;
        if (exp_dest == 3'b000) begin
          exp_drops = exp_drops + 16'd1;
        end
        if (exp_dest[0]) begin
          oth_q.push_back({KIND_OTHER, leaf, exp_payload});
        end
        if (exp_dest[1]) begin
          tag_q.push_back({KIND_TAG, RO_TAT_CODE, exp_payload});
        end
        if (exp_dest[2]) begin
          // global field swapped for its route, tag and count kept
          routed.data          = exp_payload;
          routed.tg.global_tag = route_model[routed.tg.global_tag];
          chip_q.push_back(routed.data);
        end
      end
      if (cfg_we) begin
        route_model[cfg_addr] = cfg_route;
      end
      drained <= (tag_q.size() == 0) && (oth_q.size() == 0) && (chip_q.size() == 0);
    end
  end

endmodule

//--- verification/tb_bd_uplink.sv
`timescale 1ns/1ps

module tb_bd_uplink import bd_pkg::*; ();

  // expected destinations of a table word, none means dropped
  localparam logic [2:0] TO_NONE = 3'b000;
  localparam logic [2:0] TO_OTH  = 3'b001;
  localparam logic [2:0] TO_TAG  = 3'b010;
  localparam logic [2:0] TO_CHIP = 3'b100;
  localparam logic [NGLOBAL-1:0] ROUTE_KEY = 8'h5A;

  logic                 clk         = 1'b0;
  logic                 arst_n      = 1'b0;
  logic                 raw_v       = 1'b0;
  logic [BD_RAW_W-1:0]  raw_word    = '0;
  logic                 report_tags = 1'b0;
  logic                 cfg_we      = 1'b0;
  logic [NGLOBAL-1:0]   cfg_addr    = '0;
  logic [NGLOBAL-1:0]   cfg_route   = '0;
  logic                 host_a      = 1'b0;
  logic                 chip_a      = 1'b0;
  logic                 raw_a;
  logic                 host_v;
  logic [HOST_W-1:0]    host_word;
  logic                 chip_v;
  bd_payload_u          chip_payload;
  logic [15:0]          drop_count;
  logic [2:0]           exp_dest    = '0;
  logic [PAYLOAD_W-1:0] exp_payload = '0;
  int                   err_count;
  int                   chk_count;
  logic                 drained;

  // stimulus table, words grouped into named tests
  string                t_name [$];
  logic                 t_rpt [$];
  logic [BD_RAW_W-1:0]  w_word [$];
  logic [2:0]           w_dest [$];
  logic [PAYLOAD_W-1:0] w_exp [$];
  int                   w_test [$];
  logic                 table_ready = 1'b0;
  integer               seed = 32'h7c51;
  int                   n_passed = 0;
  int                   n_failed = 0;

  bd_uplink_top #(.NGLOBAL(NGLOBAL), .NTAG(NTAG), .NCT(NCT)) bd_uplink_top_i (
    .clk, .arst_n, .raw_v, .raw_a, .raw_word, .report_tags, .cfg_we, .cfg_addr,
    .cfg_route, .host_v, .host_a, .host_word, .chip_v, .chip_a, .chip_payload, .drop_count
  );

  bd_uplink_checker bd_uplink_checker_i (
    .clk, .arst_n, .raw_v, .raw_a, .raw_word, .exp_dest, .exp_payload, .cfg_we,
    .cfg_addr, .cfg_route, .host_v, .host_a, .host_word, .chip_v, .chip_a,
    .chip_payload, .drop_count, .err_count, .chk_count, .drained
  );

  always #2 clk = ~clk;

  // host side ready three cycles in four, chip side every other cycle on average
  always @(posedge clk) begin
    host_a <= ($random(seed) & 3) != 0;
    chip_a <= ($random(seed) & 1) != 0;
  end

  function automatic logic [PAYLOAD_W-1:0] tag_fields(input logic [NGLOBAL-1:0] g,
                                                      input logic [NTAG-1:0] t,
                                                      input logic [NCT-1:0] c);
    return {{(PAYLOAD_W-NGLOBAL-NTAG-NCT){1'b0}}, g, t, c};
  endfunction

  task automatic add_test(input string name, input logic rpt);
    t_name.push_back(name);
    t_rpt.push_back(rpt);
  endtask

  task automatic add_word(input logic [LEAF_W-1:0] leaf, input logic [PAYLOAD_W-1:0] payload,
                          input logic [2:0] dest, input logic [PAYLOAD_W-1:0] exp);
    w_word.push_back({leaf, payload});
    w_dest.push_back(dest);
    w_exp.push_back(exp);
    w_test.push_back(t_name.size() - 1);
  endtask

  task automatic build_table();
    add_test("other_leaves", 1'b0);
    add_word(6'd0, 34'h3_FFFF_FFFF, TO_OTH, 34'h0_001F_FFFF);
    add_word(6'd4, 34'h2_1234_5678, TO_OTH, 34'h0_0000_0678);
    add_word(6'd5, 34'h1_ABCD_EF99, TO_OTH, 34'h0_0000_0099);
    add_word(6'd6, 34'h3_DEAD_BEEF, TO_OTH, 34'h0_DEAD_BEEF);
    add_word(6'd13, 34'h1_0055_AA33, TO_OTH, 34'h0_0055_AA33);
    add_word(6'd14, 34'h0_0000_0007, TO_OTH, 34'h0_0000_0003);
    add_word(6'd1, 34'h2_5A5A_5A5A, TO_OTH, 34'h2_5A5A_5A5A);
    add_test("global_routes", 1'b1);
    add_word(RO_ACC_CODE, tag_fields(8'h01, 11'h123, 9'h045), TO_CHIP,
             tag_fields(8'h01, 11'h123, 9'h045));
    add_word(RO_TAT_CODE, tag_fields(8'h7F, 11'h7FF, 9'h1FF), TO_CHIP,
             tag_fields(8'h7F, 11'h7FF, 9'h1FF));
    add_word(RO_ACC_CODE, tag_fields(8'hE1, 11'h001, 9'h100), TO_CHIP,
             tag_fields(8'hE1, 11'h001, 9'h100));
    add_test("go_home_quiet", 1'b0);
    add_word(RO_TAT_CODE, tag_fields(8'hE0, 11'h321, 9'h012), TO_TAG,
             tag_fields(8'hE0, 11'h321, 9'h012));
    add_word(RO_ACC_CODE, tag_fields(8'hE0, 11'h004, 9'h003), TO_TAG,
             tag_fields(8'hE0, 11'h004, 9'h003));
    add_test("go_home_report", 1'b1);
    add_word(RO_TAT_CODE, tag_fields(8'hE0, 11'h321, 9'h012), TO_TAG | TO_OTH,
             tag_fields(8'hE0, 11'h321, 9'h012));
    add_word(RO_ACC_CODE, tag_fields(8'hE0, 11'h004, 9'h003), TO_TAG | TO_OTH,
             tag_fields(8'hE0, 11'h004, 9'h003));
    add_word(6'd2, 34'h0_0001_BEEF, TO_OTH, 34'h0_0000_BEEF);
    add_test("unknown_leaves", 1'b0);
    add_word(6'd8, 34'h1_2345_6789, TO_NONE, '0);
    add_word(6'd3, 34'h0_00FF_FFFF, TO_OTH, 34'h0_000F_FFFF);
    add_word(6'd20, 34'h0_0000_0001, TO_NONE, '0);
    add_word(6'd63, 34'h3_FFFF_FFFF, TO_NONE, '0);
    add_test("mixed_burst", 1'b1);
    add_word(6'd7, 34'h3_0007_FFFF, TO_OTH, 34'h0_0007_FFFF);
    add_word(RO_TAT_CODE, tag_fields(8'h10, 11'h055, 9'h0AA), TO_CHIP,
             tag_fields(8'h10, 11'h055, 9'h0AA));
    add_word(RO_ACC_CODE, tag_fields(8'hE0, 11'h7FF, 9'h001), TO_TAG | TO_OTH,
             tag_fields(8'hE0, 11'h7FF, 9'h001));
    add_word(6'd9, 34'h0_1111_2222, TO_NONE, '0);
    add_word(6'd0, 34'h0_0012_3456, TO_OTH, 34'h0_0012_3456);
    add_word(RO_ACC_CODE, tag_fields(8'hAB, 11'h3C3, 9'h0F0), TO_CHIP,
             tag_fields(8'hAB, 11'h3C3, 9'h0F0));
  endtask

  task automatic program_routes();
    for (int g = 0; g < 2**NGLOBAL; g++) begin
      cfg_we    <= 1'b1;
      cfg_addr  <= g[NGLOBAL-1:0];
      cfg_route <= g[NGLOBAL-1:0] ^ ROUTE_KEY;
      @(posedge clk);
    end
    cfg_we <= 1'b0;
  endtask

  // offer one table word and hold it until the decoder takes it
  task automatic send_word(input int k);
    raw_v       <= 1'b1;
    raw_word    <= w_word[k];
    exp_dest    <= w_dest[k];
    exp_payload <= w_exp[k];
    @(posedge clk);
    while (!raw_a) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_drained();
    @(posedge clk);
    while (!drained) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  initial begin
    int errs_before;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    program_routes();
    errs_before = 0;
    for (int t = 0; t < t_name.size(); t++) begin
      @(posedge clk);
      // report_tags only changes while nothing is in flight
      report_tags <= t_rpt[t];
      for (int k = 0; k < w_word.size(); k++) begin
        if (w_test[k] == t) begin
          send_word(k);
        end
      end
      raw_v <= 1'b0;
      wait_drained();
      if (err_count == errs_before) begin
        n_passed++;
        $display("test %s passed", t_name[t]);
      end else begin
        n_failed++;
        $display("test %s failed with %0d errors", t_name[t], err_count - errs_before);
      end
      errs_before = err_count;
    end
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             n_passed, n_failed, chk_count, err_count);
    if (n_failed == 0 && err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    int limit;
    wait (table_ready);
    limit = w_word.size() * 200;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles with words still pending", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- build.f
src/bd_pkg.sv
src/bd_word_decoder.sv
src/bd_tag_split.sv
src/global_route_table.sv
src/host_uplink_arbiter.sv
src/bd_uplink_top.sv
verification/bd_uplink_checker.sv
verification/tb_bd_uplink.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bd_uplink
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check-log clean

all: check-log

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)

check-log: run
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
